/* rtl/soc_mem_pkg.sv */
package soc_mem_pkg;

  // Data path widths
  localparam int XLEN = 32;
  localparam int STRB_W = 4;

  // Data memory and I/O decode
  localparam int DMEM_DEPTH = 1024;
  localparam int DMEM_AW = 10;
  localparam int IO_SEL_BIT = 31;

  // Debug bridge
  localparam int RX_FIFO_AW = 4;
  localparam logic [7:0] DBG_ACK = 8'hA5;

  // Opcode byte that starts every debug command
  typedef enum logic [7:0] {
    CMD_HALT    = 8'h01,
    CMD_RESUME  = 8'h02,
    CMD_RESET   = 8'h03,
    CMD_RELEASE = 8'h04,
    CMD_WRITE   = 8'h10,
    CMD_READ    = 8'h11
  } dbg_cmd_e;

  typedef enum logic [2:0] {
    ST_CMD,
    ST_ADDR,
    ST_DATA,
    ST_ACCESS,
    ST_WAIT_RD,
    ST_TX
  } dbg_state_e;

  // One data-port request, read and write side together
  typedef struct packed {
    logic              ren;
    logic [XLEN-1:0]   raddr;
    logic              wen;
    logic [XLEN-1:0]   waddr;
    logic [XLEN-1:0]   wdata;
    logic [STRB_W-1:0] wstrb;
  } dmem_req_t;

endpackage

/* rtl/rx_byte_fifo.sv */
`timescale 1ns/1ps

module rx_byte_fifo #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wr_valid,
  input  logic [7:0] wr_data,
  output logic       wr_ready,
  output logic       rd_valid,
  output logic [7:0] rd_data,
  input  logic       rd_ready
);

  logic [7:0]          mem [2**ADDR_WIDTH];
  // Extra MSB tells a full buffer from an empty one
  logic [ADDR_WIDTH:0] wr_ptr;
  logic [ADDR_WIDTH:0] rd_ptr;
  logic                full;
  logic                empty;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                 (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

  assign wr_ready = !full;
  assign rd_valid = !empty;
  assign rd_data  = mem[rd_ptr[ADDR_WIDTH-1:0]];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_valid && wr_ready) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_valid && rd_ready) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_valid && wr_ready) begin
      mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_data;
    end
  end

  // Occupancy never grows past the buffer depth
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    (ADDR_WIDTH+1)'(wr_ptr - rd_ptr) <= (ADDR_WIDTH+1)'(2**ADDR_WIDTH));

endmodule

/* rtl/dbg_bridge.sv */
`timescale 1ns/1ps

module dbg_bridge (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rx_valid,
  input  logic [7:0]             rx_data,
  output logic                   rx_ready,
  output logic                   tx_valid,
  output logic [7:0]             tx_data,
  input  logic                   tx_ready,
  output soc_mem_pkg::dmem_req_t dbg_req,
  input  logic [31:0]            rdata,
  output logic                   halt,
  output logic                   core_rst
);

  soc_mem_pkg::dbg_state_e state;
  soc_mem_pkg::dbg_cmd_e   cmd;
  logic [1:0]              byte_cnt;
  logic [1:0]              tx_cnt;
  logic [31:0]             addr;
  logic [31:0]             wdata;
  logic [31:0]             tx_shift;
  logic                    rx_fire;
  logic                    tx_fire;
  logic                    ack_cmd;
  logic                    is_write;

  assign rx_ready = (state == soc_mem_pkg::ST_CMD) || (state == soc_mem_pkg::ST_ADDR) ||
                    (state == soc_mem_pkg::ST_DATA);
  assign rx_fire  = rx_valid && rx_ready;
  assign tx_valid = (state == soc_mem_pkg::ST_TX);
  assign tx_data  = tx_shift[7:0];
  assign tx_fire  = tx_valid && tx_ready;
  assign is_write = (cmd == soc_mem_pkg::CMD_WRITE);

  // Control opcodes answer right away with a single ack
  assign ack_cmd = rx_data inside {soc_mem_pkg::CMD_HALT, soc_mem_pkg::CMD_RESUME,
                                   soc_mem_pkg::CMD_RESET, soc_mem_pkg::CMD_RELEASE};

  // Access strobes live for the single ST_ACCESS cycle
  always_comb begin
    dbg_req       = '0;
    dbg_req.raddr = addr;
    dbg_req.waddr = addr;
    dbg_req.wdata = wdata;
    dbg_req.wstrb = '1;
    if (state == soc_mem_pkg::ST_ACCESS) begin
      dbg_req.wen = is_write;
      dbg_req.ren = !is_write;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= soc_mem_pkg::ST_CMD;
      cmd      <= soc_mem_pkg::CMD_HALT;
      byte_cnt <= '0;
      tx_cnt   <= '0;
      halt     <= 1'b0;
      core_rst <= 1'b0;
    end else begin
      case (state)
        soc_mem_pkg::ST_CMD: begin
          if (rx_fire) begin
            cmd      <= soc_mem_pkg::dbg_cmd_e'(rx_data);
            byte_cnt <= '0;
            tx_cnt   <= '0;
            case (rx_data)
              soc_mem_pkg::CMD_HALT:    halt <= 1'b1;
              soc_mem_pkg::CMD_RESUME:  halt <= 1'b0;
              soc_mem_pkg::CMD_RESET:   core_rst <= 1'b1;
              soc_mem_pkg::CMD_RELEASE: core_rst <= 1'b0;
              default: ;
            endcase
            if (ack_cmd) begin
              state <= soc_mem_pkg::ST_TX;
            end else if ((rx_data == soc_mem_pkg::CMD_WRITE) ||
                         (rx_data == soc_mem_pkg::CMD_READ)) begin
              state <= soc_mem_pkg::ST_ADDR;
            end
            // Unknown opcodes are dropped here
          end
        end
        soc_mem_pkg::ST_ADDR: begin
          if (rx_fire) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 2'd3) begin
              state <= is_write ? soc_mem_pkg::ST_DATA : soc_mem_pkg::ST_ACCESS;
            end
          end
        end
        soc_mem_pkg::ST_DATA: begin
          if (rx_fire) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 2'd3) begin
              state <= soc_mem_pkg::ST_ACCESS;
            end
          end
        end
        soc_mem_pkg::ST_ACCESS: begin
          tx_cnt <= '0;
          state  <= is_write ? soc_mem_pkg::ST_TX : soc_mem_pkg::ST_WAIT_RD;
        end
        soc_mem_pkg::ST_WAIT_RD: begin
          // Four reply bytes for a read
          tx_cnt <= 2'd3;
          state  <= soc_mem_pkg::ST_TX;
        end
        soc_mem_pkg::ST_TX: begin
          if (tx_fire) begin
            tx_cnt <= tx_cnt - 1'b1;
            if (tx_cnt == 2'd0) begin
              state <= soc_mem_pkg::ST_CMD;
            end
          end
        end
        default: state <= soc_mem_pkg::ST_CMD;
      endcase
    end
  end

  // Address, write data and reply shift register, LSB first
  always_ff @(posedge clk) begin
    if (rx_fire && (state == soc_mem_pkg::ST_ADDR)) begin
      addr <= {rx_data, addr[31:8]};
    end
    if (rx_fire && (state == soc_mem_pkg::ST_DATA)) begin
      wdata <= {rx_data, wdata[31:8]};
    end
    if ((rx_fire && (state == soc_mem_pkg::ST_CMD) && ack_cmd) ||
        ((state == soc_mem_pkg::ST_ACCESS) && is_write)) begin
      tx_shift <= {24'h0, soc_mem_pkg::DBG_ACK};
    end else if (state == soc_mem_pkg::ST_WAIT_RD) begin
      tx_shift <= rdata;
    end else if (tx_fire) begin
      tx_shift <= {8'h0, tx_shift[31:8]};
    end
  end

  a_tx_stable: assert property (@(posedge clk) disable iff (!rst_n)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

endmodule

/* rtl/dmem_router.sv */
`timescale 1ns/1ps

module dmem_router (
  input  logic                   clk,
  input  logic                   rst_n,
  input  soc_mem_pkg::dmem_req_t cpu_req,
  input  soc_mem_pkg::dmem_req_t dbg_req,
  input  logic                   halt,
  output logic                   cpu_stall,
  output soc_mem_pkg::dmem_req_t mem_req,
  input  logic [31:0]            mem_rdata,
  output soc_mem_pkg::dmem_req_t io_req,
  input  logic [31:0]            io_rdata,
  output logic [31:0]            rdata
);

  soc_mem_pkg::dmem_req_t sel;
  logic                   dbg_act;
  logic                   io_rd;
  logic                   io_wr;
  logic                   io_sel_q;

  assign dbg_act   = dbg_req.ren || dbg_req.wen;
  assign cpu_stall = halt || dbg_act;

  // Debug wins; a stalled CPU access is dropped and repeated by the core
  always_comb begin
    sel = cpu_req;
    if (dbg_act) begin
      sel = dbg_req;
    end else if (halt) begin
      sel.ren = 1'b0;
      sel.wen = 1'b0;
    end
  end

  assign io_rd = sel.raddr[soc_mem_pkg::IO_SEL_BIT];
  assign io_wr = sel.waddr[soc_mem_pkg::IO_SEL_BIT];

  always_comb begin
    mem_req     = sel;
    mem_req.ren = sel.ren && !io_rd;
    mem_req.wen = sel.wen && !io_wr;
    io_req      = sel;
    io_req.ren  = sel.ren && io_rd;
    io_req.wen  = sel.wen && io_wr;
  end

  // Remembers where the last read went, so it holds between reads
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      io_sel_q <= 1'b0;
    end else if (sel.ren) begin
      io_sel_q <= io_rd;
    end
  end

  assign rdata = io_sel_q ? io_rdata : mem_rdata;

  a_one_write_target: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_req.wen && io_req.wen));

endmodule

/* rtl/data_bram.sv */
`timescale 1ns/1ps

module data_bram (
  input  logic                   clk,
  input  soc_mem_pkg::dmem_req_t mem_req,
  output logic [31:0]            rdata
);

  logic [soc_mem_pkg::XLEN-1:0]    mem [soc_mem_pkg::DMEM_DEPTH];
  logic [soc_mem_pkg::DMEM_AW-1:0] ridx;
  logic [soc_mem_pkg::DMEM_AW-1:0] widx;

  // Word index from the byte address
  assign ridx = mem_req.raddr[soc_mem_pkg::DMEM_AW+1:2];
  assign widx = mem_req.waddr[soc_mem_pkg::DMEM_AW+1:2];

  always_ff @(posedge clk) begin
    if (mem_req.wen) begin
      for (int b = 0; b < soc_mem_pkg::STRB_W; b++) begin
        if (mem_req.wstrb[b]) begin
          mem[widx][b*8 +: 8] <= mem_req.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk) begin
    if (mem_req.ren) begin
      rdata <= mem[ridx];
    end
  end

endmodule

/* rtl/soc_mem_top.sv */
`timescale 1ns/1ps

module soc_mem_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  soc_mem_pkg::dmem_req_t cpu_req,
  output logic [31:0]            cpu_rdata,
  output logic                   cpu_stall,
  output logic                   cpu_rst_n,
  output soc_mem_pkg::dmem_req_t io_req,
  input  logic [31:0]            io_rdata,
  input  logic                   urx_valid,
  input  logic [7:0]             urx_data,
  output logic                   urx_ready,
  output logic                   utx_valid,
  output logic [7:0]             utx_data,
  input  logic                   utx_ready
);

  logic                   rx_valid;
  logic [7:0]             rx_data;
  logic                   rx_ready;
  logic                   halt;
  logic                   core_rst;
  logic [31:0]            mem_rdata;
  soc_mem_pkg::dmem_req_t dbg_req;
  soc_mem_pkg::dmem_req_t mem_req;

  assign cpu_rst_n = rst_n && !core_rst;

  rx_byte_fifo #(
    .ADDR_WIDTH(soc_mem_pkg::RX_FIFO_AW)
  ) rx_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_valid(urx_valid),
    .wr_data (urx_data),
    .wr_ready(urx_ready),
    .rd_valid(rx_valid),
    .rd_data (rx_data),
    .rd_ready(rx_ready)
  );

  dbg_bridge bridge (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx_valid(rx_valid),
    .rx_data (rx_data),
    .rx_ready(rx_ready),
    .tx_valid(utx_valid),
    .tx_data (utx_data),
    .tx_ready(utx_ready),
    .dbg_req (dbg_req),
    .rdata   (cpu_rdata),
    .halt    (halt),
    .core_rst(core_rst)
  );

  dmem_router router (
    .clk      (clk),
    .rst_n    (rst_n),
    .cpu_req  (cpu_req),
    .dbg_req  (dbg_req),
    .halt     (halt),
    .cpu_stall(cpu_stall),
    .mem_req  (mem_req),
    .mem_rdata(mem_rdata),
    .io_req   (io_req),
    .io_rdata (io_rdata),
    .rdata    (cpu_rdata)
  );

  data_bram dmem (
    .clk    (clk),
    .mem_req(mem_req),
    .rdata  (mem_rdata)
  );

endmodule

/* testbench/tb_soc_mem.sv */
`timescale 1ns/1ps

module tb_soc_mem;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 16;
  localparam int NUM_TESTS   = 6;
  // Cycle budget for one directed test, generous for the back-pressure stream
  localparam int TEST_CYCLES = 2000;

  logic                   clk = 1'b0;
  logic                   rst_n;
  soc_mem_pkg::dmem_req_t cpu_req;
  logic [31:0]            cpu_rdata;
  logic                   cpu_stall;
  logic                   cpu_rst_n;
  soc_mem_pkg::dmem_req_t io_req;
  logic [31:0]            io_rdata = '0;
  logic                   urx_valid;
  logic [7:0]             urx_data;
  logic                   urx_ready;
  logic                   utx_valid;
  logic [7:0]             utx_data;
  logic                   utx_ready;

  // Reference models of the data memory and the I/O space
  logic [31:0]            mem_model [soc_mem_pkg::DMEM_DEPTH];
  logic [31:0]            io_model [soc_mem_pkg::DMEM_DEPTH];
  soc_mem_pkg::dmem_req_t io_last;
  int unsigned            io_wr_cnt = 0;
  logic [7:0]             byte_stream [$];
  logic [7:0]             reply_exp [$];
  int                     errors;
  int                     checks;

  soc_mem_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .cpu_req  (cpu_req),
    .cpu_rdata(cpu_rdata),
    .cpu_stall(cpu_stall),
    .cpu_rst_n(cpu_rst_n),
    .io_req   (io_req),
    .io_rdata (io_rdata),
    .urx_valid(urx_valid),
    .urx_data (urx_data),
    .urx_ready(urx_ready),
    .utx_valid(utx_valid),
    .utx_data (utx_data),
    .utx_ready(utx_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // I/O device: answers a read on the following cycle
  always @(posedge clk) begin
    if (io_req.ren) begin
      io_rdata <= io_model[io_req.raddr[soc_mem_pkg::DMEM_AW+1:2]];
    end
  end

  // Records every I/O write strobe
  always @(negedge clk) begin
    if (io_req.wen) begin
      io_last = io_req;
      io_wr_cnt++;
    end
  end

  function automatic logic [31:0] word_addr(input logic [9:0] idx);
    return {20'h0, idx, 2'b00};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic void queue_word(input logic [31:0] w);
    for (int i = 0; i < 4; i++) begin
      byte_stream.push_back(w[i*8 +: 8]);
    end
  endfunction

  task automatic report_failure(input string msg);
    errors++;
    $display("%0t: %s", $time, msg);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR %0t: %s got %b expected %b", $time, name, got, want);
    end
  endtask

  // Strobes always compared, address and data only where a strobe qualifies them
  task automatic check_req(input string name, input soc_mem_pkg::dmem_req_t got,
                           input soc_mem_pkg::dmem_req_t want);
    logic bad;
    checks++;
    bad = (got.ren !== want.ren) || (got.wen !== want.wen);
    if (want.ren && (got.raddr !== want.raddr)) begin
      bad = 1'b1;
    end
    if (want.wen &&
        ({got.waddr, got.wdata, got.wstrb} !== {want.waddr, want.wdata, want.wstrb})) begin
      bad = 1'b1;
    end
    if (bad) begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    soc_mem_pkg::dmem_req_t req;
    req       = '0;
    req.wen   = 1'b1;
    req.waddr = addr;
    req.wdata = data;
    req.wstrb = strb;
    @(posedge clk);
    cpu_req <= req;
    @(negedge clk);
    check_bit("cpu_stall", cpu_stall, 1'b0);
    check_bit("io_req.wen", io_req.wen, addr[soc_mem_pkg::IO_SEL_BIT]);
    @(posedge clk);
    cpu_req <= '0;
    if (!addr[soc_mem_pkg::IO_SEL_BIT]) begin
      mem_model[addr[11:2]] = merge_bytes(mem_model[addr[11:2]], data, strb);
    end
  endtask

  task automatic cpu_read(input logic [31:0] addr, output logic [31:0] data);
    soc_mem_pkg::dmem_req_t req;
    req       = '0;
    req.ren   = 1'b1;
    req.raddr = addr;
    @(posedge clk);
    cpu_req <= req;
    @(negedge clk);
    check_bit("cpu_stall", cpu_stall, 1'b0);
    check_bit("io_req.ren", io_req.ren, addr[soc_mem_pkg::IO_SEL_BIT]);
    @(posedge clk);
    cpu_req <= '0;
    @(negedge clk);
    data = cpu_rdata;
  endtask

  // Host side of the debug UART
  task automatic send_byte(input logic [7:0] b);
    @(posedge clk);
    urx_valid <= 1'b1;
    urx_data  <= b;
    @(negedge clk);
    while (!urx_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    urx_valid <= 1'b0;
  endtask

  task automatic recv_byte(output logic [7:0] b);
    @(negedge clk);
    while (!utx_valid) begin
      @(negedge clk);
    end
    b = utx_data;
    @(posedge clk);
  endtask

  task automatic send_word(input logic [31:0] w);
    for (int i = 0; i < 4; i++) begin
      send_byte(w[i*8 +: 8]);
    end
  endtask

  task automatic dbg_ctrl(input soc_mem_pkg::dbg_cmd_e cmd);
    logic [7:0] b;
    send_byte(cmd);
    recv_byte(b);
    check_byte("utx_data", b, soc_mem_pkg::DBG_ACK);
  endtask

  task automatic dbg_write(input logic [31:0] addr, input logic [31:0] data);
    logic [7:0] b;
    send_byte(soc_mem_pkg::CMD_WRITE);
    send_word(addr);
    send_word(data);
    recv_byte(b);
    check_byte("utx_data", b, soc_mem_pkg::DBG_ACK);
  endtask

  task automatic dbg_read(input logic [31:0] addr, output logic [31:0] data);
    logic [7:0] b;
    send_byte(soc_mem_pkg::CMD_READ);
    send_word(addr);
    for (int i = 0; i < 4; i++) begin
      recv_byte(b);
      data[i*8 +: 8] = b;
    end
  endtask

  // Takes the expected replies while utx_ready toggles in random stretches
  task automatic collect_replies;
    int got_n;
    int stretch;
    logic lvl;
    got_n   = 0;
    stretch = 0;
    lvl     = 1'b0;
    while (got_n < reply_exp.size()) begin
      @(posedge clk);
      if (stretch == 0) begin
        lvl     = !lvl;
        stretch = $urandom_range(1, 6);
      end
      stretch--;
      utx_ready <= lvl;
      @(negedge clk);
      if (utx_valid && utx_ready) begin
        check_byte("utx_data", utx_data, reply_exp[got_n]);
        got_n++;
      end
    end
  endtask

  task automatic apply_reset;
    repeat (RST_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_bit("cpu_rst_n", cpu_rst_n, 1'b0);
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("cpu_rst_n", cpu_rst_n, 1'b1);
    check_bit("cpu_stall", cpu_stall, 1'b0);
    check_bit("utx_valid", utx_valid, 1'b0);
    check_bit("io_req.ren", io_req.ren, 1'b0);
    check_bit("io_req.wen", io_req.wen, 1'b0);
    check_bit("urx_ready", urx_ready, 1'b1);
  endtask

  task automatic test_cpu_mem_path;
    logic [9:0]  idx [8];
    logic [31:0] got;
    int          k;
    // Full words first, so that later strobed writes merge into known data
    for (int i = 0; i < 8; i++) begin
      idx[i] = 10'($urandom);
      cpu_write(word_addr(idx[i]), $urandom, 4'hF);
    end
    for (int i = 0; i < 24; i++) begin
      k = $urandom_range(0, 7);
      cpu_write(word_addr(idx[k]), $urandom, 4'($urandom));
    end
    for (int i = 0; i < 8; i++) begin
      cpu_read(word_addr(idx[i]), got);
      check_word("cpu_rdata", got, mem_model[idx[i]]);
    end
  endtask

  task automatic test_io_decode;
    logic [9:0]             idx;
    logic [31:0]            io_addr;
    logic [31:0]            data;
    logic [3:0]             strb;
    logic [31:0]            got;
    int unsigned            cnt;
    soc_mem_pkg::dmem_req_t want;
    idx     = 10'($urandom);
    io_addr = word_addr(idx) | 32'h8000_0000;
    data    = $urandom;
    strb    = 4'($urandom) | 4'b0001;
    cpu_write(word_addr(idx), $urandom, 4'hF);
    cnt = io_wr_cnt;
    cpu_write(io_addr, data, strb);
    if (io_wr_cnt != cnt + 1) begin
      report_failure("CPU write with bit 31 set did not give exactly one I/O write");
    end
    want       = '0;
    want.wen   = 1'b1;
    want.waddr = io_addr;
    want.wdata = data;
    want.wstrb = strb;
    check_req("io_req", io_last, want);
    io_model[idx] = $urandom;
    cpu_read(io_addr, got);
    check_word("cpu_rdata", got, io_model[idx]);
    // The memory word behind the same low address is untouched
    cpu_read(word_addr(idx), got);
    check_word("cpu_rdata", got, mem_model[idx]);
  endtask

  task automatic test_halt_resume;
    dbg_ctrl(soc_mem_pkg::CMD_HALT);
    repeat (6) begin
      @(negedge clk);
      check_bit("cpu_stall", cpu_stall, 1'b1);
    end
    dbg_ctrl(soc_mem_pkg::CMD_RESUME);
    @(negedge clk);
    check_bit("cpu_stall", cpu_stall, 1'b0);
  endtask

  task automatic test_debug_access;
    logic [9:0]             idx;
    logic [31:0]            data;
    logic [31:0]            got;
    int unsigned            cnt;
    soc_mem_pkg::dmem_req_t want;
    idx  = 10'($urandom);
    data = $urandom;
    dbg_ctrl(soc_mem_pkg::CMD_HALT);
    dbg_write(word_addr(idx), data);
    mem_model[idx] = data;
    dbg_read(word_addr(idx), got);
    check_word("debug read data", got, data);
    dbg_ctrl(soc_mem_pkg::CMD_RESUME);
    cpu_read(word_addr(idx), got);
    check_word("cpu_rdata", got, mem_model[idx]);
    cnt  = io_wr_cnt;
    data = $urandom;
    dbg_write(word_addr(idx) | 32'h8000_0000, data);
    if (io_wr_cnt != cnt + 1) begin
      report_failure("Debug write with bit 31 set did not give exactly one I/O write");
    end
    want       = '0;
    want.wen   = 1'b1;
    want.waddr = word_addr(idx) | 32'h8000_0000;
    want.wdata = data;
    want.wstrb = 4'hF;
    check_req("io_req", io_last, want);
  endtask

  task automatic test_core_reset;
    dbg_ctrl(soc_mem_pkg::CMD_RESET);
    @(negedge clk);
    check_bit("cpu_rst_n", cpu_rst_n, 1'b0);
    dbg_ctrl(soc_mem_pkg::CMD_RELEASE);
    @(negedge clk);
    check_bit("cpu_rst_n", cpu_rst_n, 1'b1);
  endtask

  task automatic test_back_pressure;
    logic [9:0]  idx0;
    logic [9:0]  idx1;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] got;
    idx0 = 10'($urandom);
    idx1 = idx0 + 10'd1;
    d0   = $urandom;
    d1   = $urandom;
    byte_stream.delete();
    reply_exp.delete();
    byte_stream.push_back(soc_mem_pkg::CMD_WRITE);
    queue_word(word_addr(idx0));
    queue_word(d0);
    byte_stream.push_back(soc_mem_pkg::CMD_WRITE);
    queue_word(word_addr(idx1));
    queue_word(d1);
    byte_stream.push_back(soc_mem_pkg::CMD_READ);
    queue_word(word_addr(idx0));
    byte_stream.push_back(soc_mem_pkg::CMD_READ);
    queue_word(word_addr(idx1));
    byte_stream.push_back(soc_mem_pkg::CMD_RESUME);
    // Halt ack, two write acks, two read words, resume ack
    repeat (3) reply_exp.push_back(soc_mem_pkg::DBG_ACK);
    for (int i = 0; i < 4; i++) begin
      reply_exp.push_back(d0[i*8 +: 8]);
    end
    for (int i = 0; i < 4; i++) begin
      reply_exp.push_back(d1[i*8 +: 8]);
    end
    reply_exp.push_back(soc_mem_pkg::DBG_ACK);
    @(posedge clk);
    utx_ready <= 1'b0;
    send_byte(soc_mem_pkg::CMD_HALT);
    @(negedge clk);
    while (!utx_valid) begin
      @(negedge clk);
    end
    // Bridge is stuck on its ack, so sixteen bytes fill the FIFO
    for (int i = 0; i < 16; i++) begin
      send_byte(byte_stream[i]);
    end
    @(negedge clk);
    check_bit("urx_ready", urx_ready, 1'b0);
    fork
      begin
        for (int i = 16; i < byte_stream.size(); i++) begin
          send_byte(byte_stream[i]);
        end
      end
      collect_replies();
    join
    @(posedge clk);
    utx_ready <= 1'b1;
    mem_model[idx0] = d0;
    mem_model[idx1] = d1;
    cpu_read(word_addr(idx0), got);
    check_word("cpu_rdata", got, mem_model[idx0]);
    cpu_read(word_addr(idx1), got);
    check_word("cpu_rdata", got, mem_model[idx1]);
  endtask

  initial begin
    void'($urandom(32'h7879));
    errors    = 0;
    checks    = 0;
    rst_n     = 1'b0;
    cpu_req   = '0;
    urx_valid = 1'b0;
    urx_data  = '0;
    utx_ready = 1'b1;
    apply_reset();
    test_cpu_mem_path();
    test_io_decode();
    test_halt_resume();
    test_debug_access();
    test_core_reset();
    test_back_pressure();
    $display("tb_soc_mem: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(CLK_PERIOD * (RST_CYCLES + NUM_TESTS * TEST_CYCLES));
    $display("Timeout: the tests did not finish within %0d cycles",
             RST_CYCLES + NUM_TESTS * TEST_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* vlog.f */
rtl/soc_mem_pkg.sv
rtl/rx_byte_fifo.sv
rtl/dbg_bridge.sv
rtl/dmem_router.sv
rtl/data_bram.sv
rtl/soc_mem_top.sv
testbench/tb_soc_mem.sv

/* Makefile */
TOP := tb_soc_mem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f vlog.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
